//--- design/prf_cfg.svh
//////////////////////////////////////////////////
// physical register file sizing
// entry count, tag width and data width
//////////////////////////////////////////////////

`ifndef PRF_CFG_SVH
`define PRF_CFG_SVH

`define PRF_SIZE   32 // number of physical registers
`define PRF_IDX_W  5  // tag width, log2 of the entry count
`define PRF_DATA_W 64 // width of one register

`endif

//--- design/prf_pkg.sv
//////////////////////////////////////////////////
// prf package
// tag, word, mask and operand types shared by
// the register file blocks
//////////////////////////////////////////////////

`default_nettype none

`include "prf_cfg.svh"

package prf_pkg;

	typedef logic [`PRF_IDX_W-1:0]  prf_tag_t;  // physical register index
	typedef logic [`PRF_DATA_W-1:0] prf_word_t; // register data
	typedef logic [`PRF_SIZE-1:0]   prf_mask_t; // one bit per entry

	// a not-ready operand carries its own tag in the low bits
	typedef struct packed {
		logic [`PRF_DATA_W-`PRF_IDX_W-1:0] pad; // always zero
		prf_tag_t                          tag; // tag the station waits on
	} prf_pending_t;

	// one read word, seen as data or as a waiting tag depending on valid
	typedef union packed {
		prf_word_t    value;
		prf_pending_t pending;
	} prf_operand_t;

endpackage

`default_nettype wire

//--- design/prf_entry_if.sv
//////////////////////////////////////////////////
// prf entry interface
// entry state from the bank and the assign mask
// from the allocator, shared with the read ports
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "prf_cfg.svh"

interface prf_entry_if;

	prf_pkg::prf_mask_t assign_mask;           // entries taken by rename this cycle
	prf_pkg::prf_mask_t available;             // entry sits on the free list
	prf_pkg::prf_mask_t ready;                 // entry holds a written result
	prf_pkg::prf_word_t data [0:`PRF_SIZE-1];  // stored results

	// allocator looks at the free list and claims entries
	modport alloc (
		input  available,
		output assign_mask
	);

	// bank owns all entry state
	modport bank (
		input  assign_mask,
		output available,
		output ready,
		output data
	);

	modport reader (input available, input ready, input data); // read ports only look

endinterface

`default_nettype wire

//--- design/prf_pick.sv
//////////////////////////////////////////////////
// priority selector
// one-hot grant of the lowest set request bit
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module prf_pick #(
	parameter int WIDTH = 32
) (
	input  wire logic [WIDTH-1:0] req,
	output logic      [WIDTH-1:0] gnt
);

	logic found; // a lower request already took the grant

	// scan upward and keep only the first set bit
	always_comb
	begin
		found = 1'b0;
		gnt   = '0;
		for (int i = 0; i < WIDTH; i++)
		begin
			if (req[i] && !found)
			begin
				gnt[i] = 1'b1;
				found  = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/prf_alloc.sv
//////////////////////////////////////////////////
// tag allocator
// picks the two lowest free entries, steers them
// to the rename ports and reports full
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "prf_cfg.svh"

module prf_alloc (
	input  wire logic         alloc_req1,
	input  wire logic         alloc_req2,
	prf_entry_if.alloc        ent,
	output logic              rename_valid1,
	output logic              rename_valid2,
	output prf_pkg::prf_tag_t rename_tag1,
	output prf_pkg::prf_tag_t rename_tag2,
	output logic              full
);

	prf_pkg::prf_mask_t gnt1;   // lowest free entry
	prf_pkg::prf_mask_t gnt2;   // next free entry after gnt1
	prf_pkg::prf_mask_t avail2; // free list with gnt1 taken out
	prf_pkg::prf_mask_t take;   // grants a port actually used
	prf_pkg::prf_tag_t  tag_g1;
	prf_pkg::prf_tag_t  tag_g2;

	// one-hot to index, an all-zero mask gives tag 0
	function automatic prf_pkg::prf_tag_t onehot_to_tag(input prf_pkg::prf_mask_t oh);
		prf_pkg::prf_tag_t idx;
		idx = '0;
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (oh[i])
				idx = idx | prf_pkg::prf_tag_t'(i);
		end
		return idx;
	endfunction

	prf_pick #(.WIDTH(`PRF_SIZE)) pick1_inst (.req(ent.available), .gnt(gnt1));

	assign avail2 = ent.available & ~gnt1; // second pick must not see the first grant

	prf_pick #(.WIDTH(`PRF_SIZE)) pick2_inst (.req(avail2), .gnt(gnt2));

	assign tag_g1 = onehot_to_tag(gnt1);
	assign tag_g2 = onehot_to_tag(gnt2);

	//////////////////////////////////////////////////
	// steering of grants to the rename ports
	//////////////////////////////////////////////////
	always_comb
	begin
		rename_valid1 = 1'b0;
		rename_valid2 = 1'b0;
		rename_tag1   = '0;
		rename_tag2   = '0;
		take          = '0;
		if (alloc_req1)
		begin
			rename_valid1 = |gnt1; // low when the free list is empty
			rename_tag1   = tag_g1;
			take          = take | gnt1;
		end
		if (alloc_req2 && alloc_req1)
		begin
			rename_valid2 = |gnt2; // port 1 holds grant 1, so port 2 takes the next one
			rename_tag2   = tag_g2;
			take          = take | gnt2;
		end
		else if (alloc_req2)
		begin
			rename_valid2 = |gnt1; // port 2 alone gets the lowest free entry
			rename_tag2   = tag_g1;
			take          = take | gnt1;
		end
	end

	assign ent.assign_mask = take;               // leaves the free list at the next edge
	assign full            = ~|ent.available;    // nothing left to hand out

endmodule

`default_nettype wire

//--- design/prf_entry_bank.sv
//////////////////////////////////////////////////
// prf entry bank
// per-entry available, ready and data flops with
// bus write, retirement free and recovery decode
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "prf_cfg.svh"

module prf_entry_bank (
	input  wire logic               clock,
	input  wire logic               rst_n,
	input  wire logic               cdb1_valid,
	input  wire prf_pkg::prf_tag_t  cdb1_tag,
	input  wire prf_pkg::prf_word_t cdb1_data,
	input  wire logic               cdb2_valid,
	input  wire prf_pkg::prf_tag_t  cdb2_tag,
	input  wire prf_pkg::prf_word_t cdb2_data,
	input  wire logic               free1_valid,
	input  wire prf_pkg::prf_tag_t  free1_tag,
	input  wire logic               free2_valid,
	input  wire prf_pkg::prf_tag_t  free2_tag,
	input  wire logic               recover_valid,
	input  wire prf_pkg::prf_mask_t recover_mask,
	prf_entry_if.bank               ent
);

	prf_pkg::prf_mask_t wr_en;                    // entry named by a bus write
	prf_pkg::prf_mask_t free_en;                  // entry returns to the free list
	prf_pkg::prf_word_t wr_data [0:`PRF_SIZE-1];  // data picked per entry

	//////////////////////////////////////////////////
	// per-entry decode of writes and frees
	//////////////////////////////////////////////////
	always_comb
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			wr_en[i]   = 1'b0;
			wr_data[i] = '0;
			if (cdb1_valid && (cdb1_tag == prf_pkg::prf_tag_t'(i)))
			begin
				wr_en[i]   = 1'b1;
				wr_data[i] = cdb1_data;
			end
			// checked second so port 2 wins on a shared tag
			if (cdb2_valid && (cdb2_tag == prf_pkg::prf_tag_t'(i)))
			begin
				wr_en[i]   = 1'b1;
				wr_data[i] = cdb2_data;
			end
			free_en[i] = (free1_valid && (free1_tag == prf_pkg::prf_tag_t'(i))) ||
				(free2_valid && (free2_tag == prf_pkg::prf_tag_t'(i))) ||
				(recover_valid && recover_mask[i]); // mispredict frees the whole mask
		end
	end

	//////////////////////////////////////////////////
	// entry state
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ent.available <= '1; // everything starts on the free list
			ent.ready     <= '0;
			for (int i = 0; i < `PRF_SIZE; i++)
				ent.data[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `PRF_SIZE; i++)
			begin
				if (free_en[i])
				begin
					// a free beats a write landing in the same cycle
					ent.available[i] <= 1'b1;
					ent.ready[i]     <= 1'b0;
				end
				else if (ent.assign_mask[i])
				begin
					ent.available[i] <= 1'b0; // handed to rename, result still pending
					ent.ready[i]     <= 1'b0;
				end
				else if (wr_en[i] && !ent.available[i])
				begin
					ent.ready[i] <= 1'b1; // writes to free entries are dropped
					ent.data[i]  <= wr_data[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/prf_read.sv
//////////////////////////////////////////////////
// prf read ports
// four operand reads returning the value when
// ready, otherwise the tag to wait on
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module prf_read (
	input  wire prf_pkg::prf_tag_t rd_tag [0:3],
	prf_entry_if.reader            ent,
	output prf_pkg::prf_operand_t  rd_value [0:3],
	output logic [3:0]             rd_valid
);

	// all four ports share one lookup, so a single loop covers them
	always_comb
	begin
		for (int p = 0; p < 4; p++)
		begin
			// valid only for an allocated entry whose result has arrived
			rd_valid[p] = ent.ready[rd_tag[p]] && !ent.available[rd_tag[p]];
			if (rd_valid[p])
			begin
				rd_value[p].value = ent.data[rd_tag[p]];
			end
			else
			begin
				// hand the tag back so the reservation station can snoop the bus
				rd_value[p].pending.pad = '0;
				rd_value[p].pending.tag = rd_tag[p];
			end
		end
	end

endmodule

`default_nettype wire

//--- design/prf.sv
//////////////////////////////////////////////////
// physical register file
// free list allocation, bus writeback, frees,
// mispredict recovery and four operand reads
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module prf (
	input  wire logic                  clock,
	input  wire logic                  rst_n,
	input  wire logic                  alloc_req1,   // rename asks for a tag on port 1
	input  wire logic                  alloc_req2,   // and on port 2
	input  wire logic                  cdb1_valid,
	input  wire prf_pkg::prf_tag_t     cdb1_tag,
	input  wire prf_pkg::prf_word_t    cdb1_data,
	input  wire logic                  cdb2_valid,
	input  wire prf_pkg::prf_tag_t     cdb2_tag,
	input  wire prf_pkg::prf_word_t    cdb2_data,
	input  wire logic                  free1_valid,  // retirement releases an old mapping
	input  wire prf_pkg::prf_tag_t     free1_tag,
	input  wire logic                  free2_valid,
	input  wire prf_pkg::prf_tag_t     free2_tag,
	input  wire logic                  recover_valid, // branch mispredict
	input  wire prf_pkg::prf_mask_t    recover_mask,  // entries to drop on recovery
	input  wire prf_pkg::prf_tag_t     inst1_opa_tag,
	input  wire prf_pkg::prf_tag_t     inst1_opb_tag,
	input  wire prf_pkg::prf_tag_t     inst2_opa_tag,
	input  wire prf_pkg::prf_tag_t     inst2_opb_tag,
	output logic                       rename_valid1,
	output logic                       rename_valid2,
	output prf_pkg::prf_tag_t          rename_tag1,
	output prf_pkg::prf_tag_t          rename_tag2,
	output logic                       full,
	output prf_pkg::prf_operand_t      inst1_opa_value,
	output prf_pkg::prf_operand_t      inst1_opb_value,
	output prf_pkg::prf_operand_t      inst2_opa_value,
	output prf_pkg::prf_operand_t      inst2_opb_value,
	output logic                       inst1_opa_valid,
	output logic                       inst1_opb_valid,
	output logic                       inst2_opa_valid,
	output logic                       inst2_opb_valid
);

	prf_pkg::prf_tag_t     rd_tag [0:3];   // read ports in order opa1, opb1, opa2, opb2
	prf_pkg::prf_operand_t rd_value [0:3];
	logic [3:0]            rd_valid;

	prf_entry_if ent_if ();

	prf_alloc alloc_inst (
		.alloc_req1    (alloc_req1),
		.alloc_req2    (alloc_req2),
		.ent           (ent_if.alloc),
		.rename_valid1 (rename_valid1),
		.rename_valid2 (rename_valid2),
		.rename_tag1   (rename_tag1),
		.rename_tag2   (rename_tag2),
		.full          (full)
	);

	prf_entry_bank bank_inst (
		.clock         (clock),
		.rst_n         (rst_n),
		.cdb1_valid    (cdb1_valid),
		.cdb1_tag      (cdb1_tag),
		.cdb1_data     (cdb1_data),
		.cdb2_valid    (cdb2_valid),
		.cdb2_tag      (cdb2_tag),
		.cdb2_data     (cdb2_data),
		.free1_valid   (free1_valid),
		.free1_tag     (free1_tag),
		.free2_valid   (free2_valid),
		.free2_tag     (free2_tag),
		.recover_valid (recover_valid),
		.recover_mask  (recover_mask),
		.ent           (ent_if.bank)
	);

	assign rd_tag[0] = inst1_opa_tag;
	assign rd_tag[1] = inst1_opb_tag;
	assign rd_tag[2] = inst2_opa_tag;
	assign rd_tag[3] = inst2_opb_tag;

	prf_read read_inst (
		.rd_tag   (rd_tag),
		.ent      (ent_if.reader),
		.rd_value (rd_value),
		.rd_valid (rd_valid)
	);

	assign inst1_opa_value = rd_value[0];
	assign inst1_opb_value = rd_value[1];
	assign inst2_opa_value = rd_value[2];
	assign inst2_opb_value = rd_value[3];
	assign inst1_opa_valid = rd_valid[0];
	assign inst1_opb_valid = rd_valid[1];
	assign inst2_opa_valid = rd_valid[2];
	assign inst2_opb_valid = rd_valid[3];

endmodule

`default_nettype wire

//--- testbench/prf_tb.sv
//////////////////////////////////////////////////
// prf testbench
// replays the per-cycle stimulus file against the
// register file and checks every output against a
// free list and entry state reference model
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "prf_cfg.svh"

module prf_tb;

	// one stimulus record whose bus data is filled in from the lfsr
	typedef struct packed {
		logic [3:0]                  bhv;
		logic                        req1;
		logic                        req2;
		logic                        c1v;
		prf_pkg::prf_tag_t           c1t;
		prf_pkg::prf_word_t          d1;
		logic                        c2v;
		prf_pkg::prf_tag_t           c2t;
		prf_pkg::prf_word_t          d2;
		logic                        f1v;
		prf_pkg::prf_tag_t           f1t;
		logic                        f2v;
		prf_pkg::prf_tag_t           f2t;
		logic                        rv;
		prf_pkg::prf_mask_t          rmask;
		prf_pkg::prf_tag_t [3:0]     rd;
	} rec_t;

	logic clock, rst_n, alloc_req1, alloc_req2;
	logic cdb1_valid, cdb2_valid, free1_valid, free2_valid, recover_valid;
	prf_pkg::prf_tag_t cdb1_tag, cdb2_tag, free1_tag, free2_tag;
	prf_pkg::prf_tag_t inst1_opa_tag, inst1_opb_tag, inst2_opa_tag, inst2_opb_tag;
	prf_pkg::prf_word_t cdb1_data, cdb2_data;
	prf_pkg::prf_mask_t recover_mask;
	logic rename_valid1, rename_valid2, full;
	prf_pkg::prf_tag_t rename_tag1, rename_tag2;
	prf_pkg::prf_operand_t inst1_opa_value, inst1_opb_value, inst2_opa_value, inst2_opb_value;
	logic inst1_opa_valid, inst1_opb_valid, inst2_opa_valid, inst2_opb_valid;

	rec_t               recs [$];                 // whole stimulus, loaded before reset ends
	logic               stim_loaded = 1'b0;
	logic [31:0]        lfsr        = 32'h95b0e56c;
	prf_pkg::prf_mask_t m_avail     = '1;         // reference free list
	prf_pkg::prf_mask_t m_ready     = '0;
	prf_pkg::prf_word_t m_data [0:`PRF_SIZE-1];
	prf_pkg::prf_mask_t exp_take;                 // grants the model expects this cycle

	prf prf_inst (.*);

	always #5 clock = ~clock; // 10 ns period

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
	function automatic prf_pkg::prf_word_t next_word();
		prf_pkg::prf_word_t w;
		for (int b = 0; b < `PRF_DATA_W; b++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			w[b] = lfsr[0];
		end
		return w;
	endfunction

	function automatic int lowest_free(input prf_pkg::prf_mask_t m);
		int idx;
		idx = -1; // no free entry left
		for (int i = `PRF_SIZE - 1; i >= 0; i--)
		begin
			if (m[i])
				idx = i;
		end
		return idx;
	endfunction

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////
	task automatic check_tag(input string name, input prf_pkg::prf_tag_t exp,
		input prf_pkg::prf_tag_t act);
		if (exp !== act)
		begin
			$display("[ERROR] %s expected %0d actual %0d", name, exp, act);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic check_operand(input string name, input prf_pkg::prf_operand_t exp,
		input prf_pkg::prf_operand_t act);
		if (exp !== act)
		begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// entry update at the edge, free first, then assign, then a write to a taken entry
	task automatic model_step(input rec_t r);
		prf_pkg::prf_tag_t t;
		logic              wr;
		logic              fr;
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			t  = prf_pkg::prf_tag_t'(i);
			wr = (r.c1v && r.c1t == t) || (r.c2v && r.c2t == t);
			fr = (r.f1v && r.f1t == t) || (r.f2v && r.f2t == t) || (r.rv && r.rmask[i]);
			if (fr)
			begin
				m_avail[i] = 1'b1;
				m_ready[i] = 1'b0;
			end
			else if (exp_take[i])
			begin
				m_avail[i] = 1'b0;
				m_ready[i] = 1'b0;
			end
			else if (wr && !m_avail[i])
			begin
				m_ready[i] = 1'b1;
				m_data[i]  = (r.c2v && r.c2t == t) ? r.d2 : r.d1; // port 2 wins
			end
		end
	endtask

	// expected rename, full and operand outputs for the inputs of this cycle
	task automatic check_cycle(input rec_t r, input int n);
		int                    g1;
		int                    t2;
		logic                  v1;
		logic                  v2;
		logic                  ok;
		prf_pkg::prf_mask_t    rest;
		prf_pkg::prf_tag_t     t;
		prf_pkg::prf_operand_t exp_op;
		prf_pkg::prf_operand_t act_op [0:3];
		logic                  act_ok [0:3];
		string                 pre;
		pre  = $sformatf("b%0d rec%0d", r.bhv, n);
		g1   = lowest_free(m_avail);
		rest = m_avail;
		if (g1 >= 0)
			rest[g1] = 1'b0;
		t2       = r.req1 ? lowest_free(rest) : g1; // port 2 alone takes the lowest tag
		v1       = r.req1 && (g1 >= 0);
		v2       = r.req2 && (t2 >= 0);
		exp_take = '0;
		if (v1)
			exp_take[g1] = 1'b1;
		if (v2)
			exp_take[t2] = 1'b1;
		check_flag({pre, " full"}, (m_avail == '0), full);
		check_flag({pre, " rename_valid1"}, v1, rename_valid1);
		check_flag({pre, " rename_valid2"}, v2, rename_valid2);
		if (v1)
			check_tag({pre, " rename_tag1"}, prf_pkg::prf_tag_t'(g1), rename_tag1);
		if (v2)
			check_tag({pre, " rename_tag2"}, prf_pkg::prf_tag_t'(t2), rename_tag2);
		act_op[0] = inst1_opa_value;
		act_op[1] = inst1_opb_value;
		act_op[2] = inst2_opa_value;
		act_op[3] = inst2_opb_value;
		act_ok[0] = inst1_opa_valid;
		act_ok[1] = inst1_opb_valid;
		act_ok[2] = inst2_opa_valid;
		act_ok[3] = inst2_opb_valid;
		for (int p = 0; p < 4; p++)
		begin
			t  = r.rd[p];
			ok = m_ready[t] && !m_avail[t]; // allocated and written
			if (ok)
				exp_op.value = m_data[t];
			else
			begin
				exp_op.pending.pad = '0;
				exp_op.pending.tag = t;
			end
			check_flag($sformatf("%s rd%0d valid", pre, p), ok, act_ok[p]);
			check_operand($sformatf("%s rd%0d value", pre, p), exp_op, act_op[p]);
		end
	endtask

	task automatic drive(input rec_t r);
		alloc_req1    <= r.req1;
		alloc_req2    <= r.req2;
		cdb1_valid    <= r.c1v;
		cdb1_tag      <= r.c1t;
		cdb1_data     <= r.d1;
		cdb2_valid    <= r.c2v;
		cdb2_tag      <= r.c2t;
		cdb2_data     <= r.d2;
		free1_valid   <= r.f1v;
		free1_tag     <= r.f1t;
		free2_valid   <= r.f2v;
		free2_tag     <= r.f2t;
		recover_valid <= r.rv;
		recover_mask  <= r.rmask;
		inst1_opa_tag <= r.rd[0];
		inst1_opb_tag <= r.rd[1];
		inst2_opa_tag <= r.rd[2];
		inst2_opb_tag <= r.rd[3];
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial
	begin
		int          fd;
		int          code;
		int          n;
		string       line;
		logic [31:0] f [0:16];
		rec_t        r;
		clock = 1'b0;
		rst_n = 1'b0;
		r     = '0;
		drive(r); // all inputs idle during reset
		for (int i = 0; i < `PRF_SIZE; i++)
			m_data[i] = '0;
		fd = $fopen("testbench/prf_stim.txt", "r");
		if (fd == 0)
		begin
			$display("stimulus file testbench/prf_stim.txt could not be opened");
			$display("** FAIL **");
			$fatal(1);
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code > 1 && line[0] != "#") // skip blank and comment lines
			begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
				if (n != 17)
				begin
					$display("stimulus line has %0d fields instead of 17: %s", n, line);
					$display("** FAIL **");
					$fatal(1);
				end
				r.bhv   = f[0][3:0];
				r.req1  = f[1][0];
				r.req2  = f[2][0];
				r.c1v   = f[3][0];
				r.c1t   = f[4][`PRF_IDX_W-1:0];
				r.c2v   = f[5][0];
				r.c2t   = f[6][`PRF_IDX_W-1:0];
				r.f1v   = f[7][0];
				r.f1t   = f[8][`PRF_IDX_W-1:0];
				r.f2v   = f[9][0];
				r.f2t   = f[10][`PRF_IDX_W-1:0];
				r.rv    = f[11][0];
				r.rmask = f[12];
				for (int p = 0; p < 4; p++)
					r.rd[p] = f[13+p][`PRF_IDX_W-1:0];
				r.d1 = next_word();
				r.d2 = next_word();
				recs.push_back(r);
			end
		end
		$fclose(fd);
		if (recs.size() == 0)
		begin
			$display("stimulus file holds no records");
			$display("** FAIL **");
			$fatal(1);
		end
		stim_loaded = 1'b1;
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;
		for (int i = 0; i < recs.size(); i++)
		begin
			@(posedge clock);
			if (i > 0)
				model_step(recs[i-1]); // the dut just took the previous record
			drive(recs[i]);
			@(negedge clock);          // outputs have settled mid cycle
			check_cycle(recs[i], i);
		end
		$display("** PASS **");
		$finish;
	end

	// watchdog scaled to twice the record count plus the reset time
	initial
	begin
		int limit;
		wait (stim_loaded);
		limit = 2 * recs.size() * 10 + 5 * 10;
		#(limit);
		$display("watchdog expired before the stimulus finished");
		$display("** FAIL **");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- testbench/prf_stim.txt
# bhv req1 req2 cdb1_v cdb1_tag cdb2_v cdb2_tag free1_v free1_tag free2_v free2_tag rec_v rec_mask
#   then four read tags, all hex, one cycle per line, bus data comes from the testbench lfsr
1 0 0 0 0 0 0 0 0 0 0 0 00000000 0 0 0 0
1 1 1 0 0 0 0 0 0 0 0 0 00000000 0 1 0 1
2 0 1 0 0 0 0 0 0 0 0 0 00000000 2 3 0 1
3 0 0 1 0 1 1 0 0 0 0 0 00000000 0 1 2 0
3 0 0 1 2 1 2 0 0 0 0 0 00000000 0 1 2 3
3 0 0 1 5 0 0 0 0 0 0 0 00000000 2 0 1 5
4 1 1 0 0 0 0 0 0 0 0 0 00000000 5 2 1 0
4 1 1 0 0 0 0 0 0 0 0 0 00000000 3 4 5 2
4 1 1 0 0 0 0 0 0 0 0 0 00000000 5 6 7 8
4 1 1 0 0 0 0 0 0 0 0 0 00000000 9 a b c
4 1 1 0 0 0 0 0 0 0 0 0 00000000 d e f 10
4 1 1 0 0 0 0 0 0 0 0 0 00000000 11 12 13 14
4 1 1 0 0 0 0 0 0 0 0 0 00000000 15 16 17 18
4 1 1 0 0 0 0 0 0 0 0 0 00000000 19 1a 1b 1c
4 1 1 0 0 0 0 0 0 0 0 0 00000000 1d 1e 1f 0
4 1 1 0 0 0 0 0 0 0 0 0 00000000 1 2 3 4
4 1 1 0 0 0 0 0 0 0 0 0 00000000 5 6 7 8
4 1 1 0 0 0 0 0 0 0 0 0 00000000 a b c d
4 1 1 0 0 0 0 0 0 0 0 0 00000000 14 15 16 17
4 1 1 0 0 0 0 0 0 0 0 0 00000000 1e 1f 0 1
4 1 1 0 0 0 0 0 0 0 0 0 00000000 1f 1e 2 0
4 1 1 0 0 0 0 0 0 0 0 0 00000000 1f 0 1 2
5 0 0 0 0 0 0 1 7 1 0 0 00000000 0 7 1f 1
5 1 0 0 0 0 0 0 0 0 0 0 00000000 0 7 0 1
6 0 0 1 a 1 d 0 0 0 0 1 00101c00 a d b 14
6 1 1 0 0 0 0 0 0 0 0 0 00000000 a d b 14
6 0 1 0 0 0 0 0 0 0 0 0 00000000 a 7 d c
6 0 0 0 0 0 0 0 0 0 0 0 00000000 1 2 d 0

//--- sources.f
+incdir+design
design/prf_pkg.sv
design/prf_entry_if.sv
design/prf_pick.sv
design/prf_alloc.sv
design/prf_entry_bank.sv
design/prf_read.sv
design/prf.sv
testbench/prf_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the register file testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module prf_tb -o prf_sim
./obj_dir/prf_sim
